// File: quad_ctrl_pkg.sv
package quad_ctrl_pkg;

  //////////////////////////////
  // widths with a meaning
  //////////////////////////////
  typedef logic signed [15:0] att_t;    // pitch, roll or yaw reading
  typedef logic        [8:0]  thrst_t;  // thrust from host
  typedef logic signed [9:0]  pterm_t;  // ~5/8 of saturated error
  typedef logic signed [11:0] dterm_t;  // D_COEFF * saturated difference
  typedef logic        [10:0] spd_t;    // unsigned motor speed

  // one reading or one setpoint, all three axes
  typedef struct packed {
    att_t ptch;
    att_t roll;
    att_t yaw;
  } attitude_t;

  typedef struct packed {
    attitude_t d_att;         // desired attitude
    thrst_t    thrst;
    logic      inertial_cal;  // run all motors at CAL_SPEED
  } cmd_t;

  typedef struct packed {
    spd_t frnt;
    spd_t bck;
    spd_t lft;
    spd_t rght;
  } motor_spd_t;

  //////////////////////////////
  // control constants
  //////////////////////////////
  localparam spd_t               CAL_SPEED     = 11'h290;
  localparam logic        [12:0] MIN_RUN_SPEED = 13'h2C0;  // idle speed while running
  localparam logic signed [4:0]  D_COEFF       = 5'sd7;

  // apb register map, byte offsets
  localparam logic [7:0] REG_D_PTCH = 8'h00;
  localparam logic [7:0] REG_D_ROLL = 8'h04;
  localparam logic [7:0] REG_D_YAW  = 8'h08;
  localparam logic [7:0] REG_THRST  = 8'h0C;
  localparam logic [7:0] REG_CTRL   = 8'h10;  // bit 0 is inertial_cal
  localparam logic [7:0] REG_SPD_FB = 8'h14;  // read only, frnt [10:0], bck [26:16]
  localparam logic [7:0] REG_SPD_LR = 8'h18;  // read only, lft [10:0], rght [26:16]

endpackage

// File: pd_math.sv
`timescale 1ns/1ns

module pd_math #(
  parameter int D_QUEUE_DEPTH = 4  // samples back for the D difference
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  vld,      // new inertial reading
  input  quad_ctrl_pkg::att_t   desired,
  input  quad_ctrl_pkg::att_t   actual,
  output quad_ctrl_pkg::pterm_t pterm,
  output quad_ctrl_pkg::dterm_t dterm
);

  logic signed [16:0] err_full;                 // actual - desired, one guard bit
  logic signed [9:0]  err_sat;                  // clipped to -512..511
  logic signed [9:0]  err_q [D_QUEUE_DEPTH+1];  // [0] newest, [D_QUEUE_DEPTH] oldest
  logic signed [10:0] d_diff;                   // newest - oldest
  logic signed [6:0]  d_sat;                    // clipped to -64..63

  //////////////////////////////
  // error and saturation
  //////////////////////////////
  assign err_full = $signed({actual[15], actual}) - $signed({desired[15], desired});

  always_comb begin
    if (err_full > 17'sd511) begin
      err_sat = 10'sd511;
    end else if (err_full < -17'sd512) begin
      err_sat = 10'h200;  // -512
    end else begin
      err_sat = err_full[9:0];
    end
  end

  //////////////////////////////
  // error history
  //////////////////////////////
  // shifts only on vld so the D term spans readings, not cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i <= D_QUEUE_DEPTH; i++) begin
        err_q[i] <= '0;
      end
    end else if (vld) begin
      err_q[0] <= err_sat;
      for (int i = 1; i <= D_QUEUE_DEPTH; i++) begin
        err_q[i] <= err_q[i-1];  // age each entry by one reading
      end
    end
  end

  // p term: e/2 + e/8, arithmetic shifts keep the sign
  assign pterm = (err_q[0] >>> 1) + (err_q[0] >>> 3);

  //////////////////////////////
  // derivative
  //////////////////////////////
  assign d_diff = $signed({err_q[0][9], err_q[0]}) -
                  $signed({err_q[D_QUEUE_DEPTH][9], err_q[D_QUEUE_DEPTH]});

  always_comb begin
    if (d_diff > 11'sd63) begin
      d_sat = 7'sd63;
    end else if (d_diff < -11'sd64) begin
      d_sat = 7'h40;  // -64
    end else begin
      d_sat = d_diff[6:0];
    end
  end

  // 63*7 and -64*7 both fit easily in 12 bits
  assign dterm = d_sat * quad_ctrl_pkg::D_COEFF;

endmodule

// File: flght_cntrl.sv
`timescale 1ns/1ns

module flght_cntrl #(
  parameter int D_QUEUE_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      vld,      // inertial reading strobe
  input  quad_ctrl_pkg::cmd_t       cmd,      // setpoint, thrust, cal bit
  input  quad_ctrl_pkg::attitude_t  actual,
  output quad_ctrl_pkg::motor_spd_t spd,
  output logic                      spd_vld   // one cycle per reading
);

  quad_ctrl_pkg::pterm_t     ptch_pterm, roll_pterm, yaw_pterm;
  quad_ctrl_pkg::dterm_t     ptch_dterm, roll_dterm, yaw_dterm;
  logic [12:0]               ptch_pd, roll_pd, yaw_pd;  // p + d per axis, 13b two's comp
  logic [12:0]               base;                      // min run speed + thrust
  logic [12:0]               frnt_sum, bck_sum, lft_sum, rght_sum;
  quad_ctrl_pkg::motor_spd_t spd_sat;
  logic                      vld_d;                     // terms settle one edge after vld

  // sign extend both terms to 13 bits and add
  function automatic logic [12:0] axis_sum(input quad_ctrl_pkg::pterm_t p,
                                           input quad_ctrl_pkg::dterm_t d);
    return {{3{p[9]}}, p} + {d[11], d};
  endfunction

  // top two bits set means overflow or negative, pin to full speed
  function automatic quad_ctrl_pkg::spd_t sat_spd(input logic [12:0] sum);
    return (|sum[12:11]) ? 11'h7FF : sum[10:0];
  endfunction

  //////////////////////////////
  // one pd block per axis
  //////////////////////////////
  pd_math #(.D_QUEUE_DEPTH(D_QUEUE_DEPTH)) i_ptch (
    .clk(clk), .rst_n(rst_n), .vld(vld),
    .desired(cmd.d_att.ptch), .actual(actual.ptch),
    .pterm(ptch_pterm), .dterm(ptch_dterm)
  );

  pd_math #(.D_QUEUE_DEPTH(D_QUEUE_DEPTH)) i_roll (
    .clk(clk), .rst_n(rst_n), .vld(vld),
    .desired(cmd.d_att.roll), .actual(actual.roll),
    .pterm(roll_pterm), .dterm(roll_dterm)
  );

  pd_math #(.D_QUEUE_DEPTH(D_QUEUE_DEPTH)) i_yaw (
    .clk(clk), .rst_n(rst_n), .vld(vld),
    .desired(cmd.d_att.yaw), .actual(actual.yaw),
    .pterm(yaw_pterm), .dterm(yaw_dterm)
  );

  assign ptch_pd = axis_sum(ptch_pterm, ptch_dterm);
  assign roll_pd = axis_sum(roll_pterm, roll_dterm);
  assign yaw_pd  = axis_sum(yaw_pterm, yaw_dterm);

  //////////////////////////////
  // mixer
  //////////////////////////////
  assign base = quad_ctrl_pkg::MIN_RUN_SPEED + {4'h0, cmd.thrst};  // thrust is unsigned

  assign frnt_sum = base - ptch_pd - yaw_pd;  // nose down pushes front up
  assign bck_sum  = base + ptch_pd - yaw_pd;
  assign lft_sum  = base - roll_pd + yaw_pd;
  assign rght_sum = base + roll_pd + yaw_pd;  // front/back spin opposite to left/right

  assign spd_sat.frnt = sat_spd(frnt_sum);
  assign spd_sat.bck  = sat_spd(bck_sum);
  assign spd_sat.lft  = sat_spd(lft_sum);
  assign spd_sat.rght = sat_spd(rght_sum);

  // speed register, cal override applied here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d   <= 1'b0;
      spd_vld <= 1'b0;
      spd     <= '0;
    end else begin
      vld_d   <= vld;
      spd_vld <= vld_d;  // pulses with the load below
      if (vld_d) begin
        spd <= cmd.inertial_cal ? '{default: quad_ctrl_pkg::CAL_SPEED} : spd_sat;
      end
    end
  end

endmodule

// File: cmd_regs.sv
`timescale 1ns/1ns

module cmd_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  input  quad_ctrl_pkg::motor_spd_t spd,      // current speeds for readback
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output quad_ctrl_pkg::cmd_t       cmd
);

  logic        setup_ph;   // psel high, penable low
  logic        access_ph;  // psel and penable high
  logic        wr_en;
  logic        addr_ok;    // paddr hits the map
  logic        addr_ro;    // paddr is a readback word
  logic [31:0] rd_data;

  assign setup_ph  = psel & ~penable;
  assign access_ph = psel & penable;
  assign wr_en     = access_ph & pwrite;
  assign pready    = 1'b1;  // zero wait states

  //////////////////////////////
  // address decode, read mux
  //////////////////////////////
  always_comb begin
    rd_data = '0;
    addr_ok = 1'b1;
    addr_ro = 1'b0;
    case (paddr)
      quad_ctrl_pkg::REG_D_PTCH: rd_data = {16'h0, cmd.d_att.ptch};
      quad_ctrl_pkg::REG_D_ROLL: rd_data = {16'h0, cmd.d_att.roll};
      quad_ctrl_pkg::REG_D_YAW:  rd_data = {16'h0, cmd.d_att.yaw};
      quad_ctrl_pkg::REG_THRST:  rd_data = {23'h0, cmd.thrst};
      quad_ctrl_pkg::REG_CTRL:   rd_data = {31'h0, cmd.inertial_cal};
      quad_ctrl_pkg::REG_SPD_FB: begin
        rd_data = {5'h0, spd.bck, 5'h0, spd.frnt};
        addr_ro = 1'b1;
      end
      quad_ctrl_pkg::REG_SPD_LR: begin
        rd_data = {5'h0, spd.rght, 5'h0, spd.lft};
        addr_ro = 1'b1;
      end
      default: addr_ok = 1'b0;  // unaligned or past the map
    endcase
  end

  //////////////////////////////
  // command registers
  //////////////////////////////
  // written on the edge that ends the access phase, data truncated
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd <= '0;
    end else if (wr_en) begin
      case (paddr)
        quad_ctrl_pkg::REG_D_PTCH: cmd.d_att.ptch  <= pwdata[15:0];
        quad_ctrl_pkg::REG_D_ROLL: cmd.d_att.roll  <= pwdata[15:0];
        quad_ctrl_pkg::REG_D_YAW:  cmd.d_att.yaw   <= pwdata[15:0];
        quad_ctrl_pkg::REG_THRST:  cmd.thrst       <= pwdata[8:0];
        quad_ctrl_pkg::REG_CTRL:   cmd.inertial_cal <= pwdata[0];
        default: ;  // readback words and holes stay untouched
      endcase
    end
  end

  // response captured in setup so it is stable for the whole access phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      pslverr <= setup_ph & (~addr_ok | (pwrite & addr_ro));
      prdata  <= (setup_ph & ~pwrite) ? rd_data : '0;  // 0 outside a read
    end
  end

endmodule

// File: quad_ctrl_top.sv
`timescale 1ns/1ns

module quad_ctrl_top #(
  parameter int D_QUEUE_DEPTH = 4  // readings back for the D term
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // apb slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  // inertial side
  input  logic                      vld,
  input  quad_ctrl_pkg::attitude_t  actual,
  // motors
  output quad_ctrl_pkg::motor_spd_t spd,
  output logic                      spd_vld
);

  quad_ctrl_pkg::cmd_t cmd;  // host commands into the mixer

  //////////////////////////////
  // host registers
  //////////////////////////////
  cmd_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .spd     (spd),      // looped back for readback
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd     (cmd)
  );

  //////////////////////////////
  // attitude control
  //////////////////////////////
  flght_cntrl #(.D_QUEUE_DEPTH(D_QUEUE_DEPTH)) u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .cmd     (cmd),
    .actual  (actual),
    .spd     (spd),
    .spd_vld (spd_vld)
  );

endmodule

// File: quad_ctrl_asserts.sv
`timescale 1ns/1ns

module quad_ctrl_asserts (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic vld,
  input logic spd_vld
);

  int n_fired;  // failed assertions so far

  //////////////////////////////
  // apb side
  //////////////////////////////
  a_pready_high : assert property (@(posedge clk) pready)  // zero wait states
    else begin
      $error("pready went low");
      n_fired++;
    end

  a_pslverr_access : assert property (@(posedge clk) pslverr |-> (psel && penable))
    else begin
      $error("pslverr high outside an access phase");
      n_fired++;
    end

  //////////////////////////////
  // speed strobe
  //////////////////////////////
  // a strobe stays up a second cycle only when the next reading came right behind
  a_spd_vld_pulse : assert property (@(posedge clk) disable iff (!rst_n)
                                     (spd_vld && !$past(vld)) |=> !spd_vld)
    else begin
      $error("spd_vld held for two cycles with no second reading");
      n_fired++;
    end

  a_spd_vld_reset : assert property (@(posedge clk) !rst_n |-> !spd_vld)
    else begin
      $error("spd_vld high during reset");
      n_fired++;
    end

endmodule

// every port name matches a signal of the top level
bind quad_ctrl_top quad_ctrl_asserts u_asserts (.*);

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
  parameter int D_QUEUE_DEPTH = 4
) (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      psel,
  input logic                      penable,
  input logic                      pwrite,
  input logic [7:0]                paddr,
  input logic [31:0]               pwdata,
  input logic [31:0]               prdata,
  input logic                      pslverr,
  input logic                      vld,
  input quad_ctrl_pkg::attitude_t  actual,
  input quad_ctrl_pkg::motor_spd_t spd,
  input logic                      spd_vld
);

  int                        pass_cnt;
  int                        fail_cnt;
  int                        test_errs;                   // failures in the running test
  int                        cyc;                         // negedges since reset
  string                     cur_name;
  int                        err_m [3][D_QUEUE_DEPTH+1];  // error history, [k][0] newest
  quad_ctrl_pkg::attitude_t  m_des;                       // register model
  int                        m_thr;
  bit                        m_cal;
  quad_ctrl_pkg::motor_spd_t exp_q [$];                   // readings still in flight
  int                        due_q [$];                   // cycle each one must show up
  quad_ctrl_pkg::motor_spd_t last_spd;

  function automatic int clip(input int v, input int lo, input int hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  // negative or past 11 bits means top bits set, full speed
  function automatic quad_ctrl_pkg::spd_t to_spd(input int s);
    return (s < 0 || s > 2047) ? 11'h7FF : 11'(s);
  endfunction

  task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("error %s %s expected %0h actual %0h", cur_name, what, exp, act);
    test_errs++;
  endtask

  task automatic note_failure(input string msg);
    $display("test %s failed, %s", cur_name, msg);
    test_errs++;
  endtask

  task automatic start_test(input string name);
    cur_name  = name;
    test_errs = 0;
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////
  task automatic model_reading();
    int                        a [3];
    int                        d [3];
    int                        pd [3];
    int                        base;
    quad_ctrl_pkg::motor_spd_t e;
    a = '{int'(actual.ptch), int'(actual.roll), int'(actual.yaw)};
    d = '{int'(m_des.ptch), int'(m_des.roll), int'(m_des.yaw)};
    for (int k = 0; k < 3; k++) begin
      for (int i = D_QUEUE_DEPTH; i > 0; i--) begin
        err_m[k][i] = err_m[k][i-1];
      end
      err_m[k][0] = clip(a[k] - d[k], -512, 511);
      // p is e/2 + e/8 rounded down, d is 7 times the clipped difference
      pd[k] = (err_m[k][0] >>> 1) + (err_m[k][0] >>> 3) +
              7 * clip(err_m[k][0] - err_m[k][D_QUEUE_DEPTH], -64, 63);
    end
    base   = 'h2C0 + m_thr;              // min run speed plus thrust
    e.frnt = to_spd(base - pd[0] - pd[2]);
    e.bck  = to_spd(base + pd[0] - pd[2]);
    e.lft  = to_spd(base - pd[1] + pd[2]);
    e.rght = to_spd(base + pd[1] + pd[2]);
    if (m_cal) begin
      e = {4{11'h290}};                  // calibration speed on all motors
    end
    exp_q.push_back(e);
    due_q.push_back(cyc + 2);            // two edges after vld is sampled
  endtask

  task automatic check_speed();
    if (exp_q.size() == 0) begin
      note_failure("a speed update came with no reading pending");
    end else begin
      if (cyc != due_q.pop_front()) begin
        note_failure("a speed update did not come two edges after its reading");
      end
      last_spd = exp_q.pop_front();
      if (spd !== last_spd) begin
        mismatch("speeds", last_spd, spd);  // frnt bck lft rght packed
      end
    end
  endtask

  //////////////////////////////
  // apb watcher
  //////////////////////////////
  task automatic check_apb();
    logic [31:0] rd;
    bit          hit;
    bit          ro;
    rd  = '0;
    hit = 1'b1;
    ro  = 1'b0;
    case (paddr)
      quad_ctrl_pkg::REG_D_PTCH: rd = {16'h0, m_des.ptch};
      quad_ctrl_pkg::REG_D_ROLL: rd = {16'h0, m_des.roll};
      quad_ctrl_pkg::REG_D_YAW:  rd = {16'h0, m_des.yaw};
      quad_ctrl_pkg::REG_THRST:  rd = 32'(m_thr);
      quad_ctrl_pkg::REG_CTRL:   rd = {31'h0, m_cal};
      quad_ctrl_pkg::REG_SPD_FB: begin
        rd = {5'h0, last_spd.bck, 5'h0, last_spd.frnt};
        ro = 1'b1;
      end
      quad_ctrl_pkg::REG_SPD_LR: begin
        rd = {5'h0, last_spd.rght, 5'h0, last_spd.lft};
        ro = 1'b1;
      end
      default: hit = 1'b0;
    endcase
    if (pslverr !== (!hit || (pwrite && ro))) begin
      mismatch($sformatf("pslverr at %0h", paddr), !hit || (pwrite && ro), pslverr);
    end
    if (!pwrite && prdata !== rd) begin
      mismatch($sformatf("prdata at %0h", paddr), rd, prdata);
    end
    if (pwrite && hit && !ro) begin
      case (paddr)
        quad_ctrl_pkg::REG_D_PTCH: m_des.ptch = pwdata[15:0];
        quad_ctrl_pkg::REG_D_ROLL: m_des.roll = pwdata[15:0];
        quad_ctrl_pkg::REG_D_YAW:  m_des.yaw  = pwdata[15:0];
        quad_ctrl_pkg::REG_THRST:  m_thr      = int'(pwdata[8:0]);
        default:                   m_cal      = pwdata[0];
      endcase
    end
  endtask

  // inputs settle 1 ns after posedge, so the negedge sees what the next edge samples
  always @(negedge clk) begin
    if (!rst_n) begin
      cyc      = 0;
      m_des    = '0;
      m_thr    = 0;
      m_cal    = 1'b0;
      last_spd = '0;
      for (int k = 0; k < 3; k++) begin
        for (int i = 0; i <= D_QUEUE_DEPTH; i++) begin
          err_m[k][i] = 0;
        end
      end
    end else begin
      cyc++;
      if (psel && penable) begin
        check_apb();
      end
      if (spd_vld) begin
        check_speed();
      end
      if (vld) begin
        model_reading();
      end
    end
  end

  // drains the readings in flight, then one line for the test
  task automatic finish_test(input int exp_frnt);
    int n;
    int limit;
    n     = 0;
    limit = 20 * exp_q.size();
    while (exp_q.size() > 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() > 0) begin
      note_failure("no speed update within 20 cycles");
      exp_q.delete();
      due_q.delete();
    end
    if (exp_frnt >= 0 && spd.frnt !== exp_frnt[10:0]) begin
      mismatch("final front speed", exp_frnt, spd.frnt);
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("pass %s", cur_name);
    end else begin
      fail_cnt++;
      $display("fail %s with %0d errors", cur_name, test_errs);
    end
  endtask

endmodule

// File: tb_quad_ctrl.sv
`timescale 1ns/1ns

module tb_quad_ctrl;

  localparam int QD = 4;  // D queue depth under test

  logic                      clk;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [7:0]                paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      vld;
  quad_ctrl_pkg::attitude_t  actual;
  quad_ctrl_pkg::motor_spd_t spd;
  logic                      spd_vld;

  //////////////////////////////
  // stimulus table
  //////////////////////////////
  string                    row_name [$];
  quad_ctrl_pkg::attitude_t row_des  [$];
  int                       row_thr  [$];
  bit                       row_cal  [$];
  bit                       row_rnd  [$];  // random attitudes with vld back to back
  int                       row_exp  [$];  // front speed after the row or -1 for model only
  int                       row_n    [$];
  quad_ctrl_pkg::attitude_t smp_q    [$];  // samples of all rows in order

  quad_ctrl_top #(.D_QUEUE_DEPTH(QD)) dut0 (.*);

  tb_checker #(.D_QUEUE_DEPTH(QD)) chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic quad_ctrl_pkg::attitude_t att(input int p, input int r, input int y);
    return {p[15:0], r[15:0], y[15:0]};
  endfunction

  function automatic quad_ctrl_pkg::attitude_t rand_att();
    int v [3];
    foreach (v[i]) begin
      v[i] = int'($urandom_range(1400)) - 700;  // covers the clipping edges
    end
    return att(v[0], v[1], v[2]);
  endfunction

  task automatic add_row(input string name, input quad_ctrl_pkg::attitude_t des, input int thr,
                         input bit cal, input bit rnd, input int exp_frnt);
    row_name.push_back(name);
    row_des.push_back(des);
    row_thr.push_back(thr);
    row_cal.push_back(cal);
    row_rnd.push_back(rnd);
    row_exp.push_back(exp_frnt);
    row_n.push_back(0);
  endtask

  task automatic add_smp(input quad_ctrl_pkg::attitude_t a, input int reps);
    repeat (reps) smp_q.push_back(a);
    row_n[row_n.size()-1] += reps;
  endtask

  // one apb transfer of setup then access until pready
  task automatic apb_xfer(input bit wr, input logic [7:0] addr, input logic [31:0] data);
    int n;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pready && n < 8);
    if (!pready) begin
      chk0.note_failure("apb transfer got no pready within 8 cycles");
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  initial begin
    int si;
    void'($urandom(83748));
    rst_n   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    vld     = 1'b0;
    actual  = '0;
    si      = 0;

    add_row("hover", att(10, -20, 30), 'h40, 1'b0, 1'b0, 'h300);
    add_smp(att(10, -20, 30), 6);
    add_row("pitch_step", att(0, 0, 0), 'h80, 1'b0, 1'b0, 770);
    add_smp(att(100, 0, 0), 6);                 // d clipped at 63 on the step
    add_row("roll_step", att(0, 0, 0), 'h80, 1'b0, 1'b0, 832);
    add_smp(att(0, -300, 0), 6);
    add_row("yaw_err_sat", att(0, 0, -1000), 'h80, 1'b0, 1'b0, 514);
    add_smp(att(0, 0, 1000), 6);                // error 2000 clips to 511
    add_row("out_sat_high", att(0, 0, 0), 'h1FF, 1'b0, 1'b0, -1);
    add_smp(att(800, 0, -800), 1);
    add_row("out_sat_neg", att(0, 0, 0), 0, 1'b0, 1'b0, 'h7FF);
    add_smp(att(800, 0, 800), 1);
    add_row("cal_on", att(0, 0, 0), 'h40, 1'b1, 1'b0, 'h290);
    add_smp(att(50, -50, 200), 3);
    add_row("cal_off", att(0, 0, 0), 'h40, 1'b0, 1'b0, 'h300);
    add_smp(att(0, 0, 0), 6);
    add_row("b2b_random", att(0, 0, 0), 'h60, 1'b0, 1'b1, -1);
    add_smp(att(0, 0, 0), 16);                  // placeholders that random values replace

    #2 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int r = 0; r < row_name.size(); r++) begin
      chk0.start_test(row_name[r]);
      apb_xfer(1'b1, quad_ctrl_pkg::REG_D_PTCH, {16'h0, row_des[r].ptch});
      apb_xfer(1'b1, quad_ctrl_pkg::REG_D_ROLL, {16'h0, row_des[r].roll});
      apb_xfer(1'b1, quad_ctrl_pkg::REG_D_YAW, {16'h0, row_des[r].yaw});
      apb_xfer(1'b1, quad_ctrl_pkg::REG_THRST, 32'(row_thr[r]));
      apb_xfer(1'b1, quad_ctrl_pkg::REG_CTRL, 32'(row_cal[r]));
      for (int k = 0; k < row_n[r]; k++) begin
        @(posedge clk);
        #1;
        vld    = 1'b1;
        actual = row_rnd[r] ? rand_att() : smp_q[si];
        si++;
        if (!row_rnd[r]) begin
          @(posedge clk);
          #1;
          vld = 1'b0;
          repeat (2) @(posedge clk);            // gap between readings
        end
      end
      @(posedge clk);
      #1;
      vld = 1'b0;
      chk0.finish_test(row_exp[r]);
    end

    //////////////////////////////
    // register access
    //////////////////////////////
    chk0.start_test("reg_access");
    apb_xfer(1'b1, quad_ctrl_pkg::REG_D_ROLL, 32'hDEAD_8001);  // upper half dropped
    apb_xfer(1'b1, quad_ctrl_pkg::REG_THRST, 32'hFFFF_FE5A);   // 9 bits kept
    apb_xfer(1'b1, quad_ctrl_pkg::REG_CTRL, 32'h0000_0006);    // bit 0 only
    apb_xfer(1'b1, quad_ctrl_pkg::REG_SPD_LR, 32'hFFFF_FFFF);  // read only
    apb_xfer(1'b1, 8'h40, 32'h1234_5678);                      // past the map
    apb_xfer(1'b0, 8'h02, '0);                                  // unaligned
    for (int ad = 0; ad <= 'h1C; ad += 4) begin
      apb_xfer(1'b0, 8'(ad), '0);
    end
    chk0.finish_test(-1);

    $display("tests passed %0d failed %0d assertion failures %0d", chk0.pass_cnt,
             chk0.fail_cnt, dut0.u_asserts.n_fired);
    if (chk0.fail_cnt == 0 && dut0.u_asserts.n_fired == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: quad_ctrl.f
quad_ctrl_pkg.sv
pd_math.sv
flght_cntrl.sv
cmd_regs.sv
quad_ctrl_top.sv
quad_ctrl_asserts.sv
tb_checker.sv
tb_quad_ctrl.sv
